// File: test/pixel_vectors.txt
# mcm bmm ecm idle xscroll pixels char b0c b1c b2c b3c ec main_border vborder
#   sprite_code sprite_pri sprite_mmc sprite_col mc0 mc1, then pixels 0..7 (msb first), all hex
# hires char and bitmap
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0000 00 00 00000000 a f 7 6 7 6 6 7 6 7
0 0 0 0 5 a5 741 6 2 5 9 e 0 0 0000 00 00 00000000 a f 7 6 7 6 6 7 6 7
0 0 0 0 7 3c 741 6 2 5 9 e 0 0 0000 00 00 00000000 a f 6 6 7 7 7 7 6 6
0 1 0 0 0 a5 03c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 3 c 3 c c 3 c 3
0 1 0 0 5 96 03c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 3 c c 3 c 3 3 c
# multicolour char, hires fallback, multicolour bitmap
1 0 0 0 0 1b b41 6 2 5 9 e 0 0 0000 00 00 00000000 a f 6 6 2 2 5 5 3 3
1 0 0 0 3 e4 b41 6 2 5 9 e 0 0 0000 00 00 00000000 a f 3 3 5 5 2 2 6 6
1 0 0 0 0 a5 541 6 2 5 9 e 0 0 0000 00 00 00000000 a f 5 6 5 6 6 5 6 5
1 1 0 0 0 1b 73c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 6 6 3 3 c c 7 7
1 1 0 0 6 e4 73c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 7 7 c c 3 3 6 6
# extended background, one per background register
0 0 1 0 0 f0 d01 6 2 5 9 e 0 0 0000 00 00 00000000 a f d d d d 6 6 6 6
0 0 1 0 0 33 741 6 2 5 9 e 0 0 0000 00 00 00000000 a f 2 2 7 7 2 2 7 7
0 0 1 0 0 a5 781 6 2 5 9 e 0 0 0000 00 00 00000000 a f 7 5 7 5 5 7 5 7
0 0 1 0 2 0f 4c1 6 2 5 9 e 0 0 0000 00 00 00000000 a f 9 9 9 9 4 4 4 4
# illegal modes
1 0 1 0 0 a5 b41 6 2 5 9 e 0 0 0000 00 00 00000000 a f 0 0 0 0 0 0 0 0
0 1 1 0 0 a5 73c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 0 0 0 0 0 0 0 0
1 1 1 0 0 1b 73c 6 2 5 9 e 0 0 0000 00 00 00000000 a f 0 0 0 0 0 0 0 0
# sprites over standard char
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0002 00 00 0000000d a f d d d d d d d d
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0002 01 00 0000000d a f 7 d 7 d d 7 d 7
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0010 00 04 00000300 a f a a a a a a a a
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0020 00 04 00000300 a f 3 3 3 3 3 3 3 3
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0030 00 04 00000300 a f f f f f f f f f
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 000c 02 02 00000000 a f 7 f 7 f f 7 f 7
0 0 0 0 0 a5 741 6 2 5 9 e 0 0 0082 00 00 0000d002 a f 2 2 2 2 2 2 2 2
# main border and vertical border
0 0 0 0 0 a5 741 6 2 5 9 e 1 0 0000 00 00 00000000 a f e e e e e e e e
0 0 0 0 0 a5 741 6 2 5 9 e 0 1 0000 00 00 00000000 a f 6 6 6 6 6 6 6 6

// File: list.f
hw/vic_timing_pkg.sv
hw/vic_color_pkg.sv
hw/dot_phase_gen.sv
hw/char_fetch_latch.sv
hw/pixel_shifter.sv
hw/mode_color_sel.sv
hw/sprite_border_mix.sv
hw/pixel_sequencer.sv
test/tb_clock_gen.sv
test/tb_pixel_sequencer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pixel sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_pixel_sequencer \
    -Mdir obj_dir \
    -f list.f

./obj_dir/Vtb_pixel_sequencer

// File: test/tb_pixel_sequencer.sv
module tb_pixel_sequencer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SPRITES    = 8;
    localparam int LINE_CYCLES    = vic_timing_pkg::CYCLES_PER_LINE;
    localparam int PHI_CLOCKS     = 32;
    localparam int CHECK_CYCLE    = 30;
    localparam int NUM_FIELDS     = 28;
    localparam int RESET_TIMEOUT  = 100;
    localparam int CYCLE_TIMEOUT  = 4096;
    localparam int STROBE_TIMEOUT = 64;

    logic                                         clk_dot4x;
    logic                                         rst;
    logic                                         mcm;
    logic                                         bmm;
    logic                                         ecm;
    logic                                         idle;
    vic_timing_pkg::dot_t                         xscroll;
    logic [7:0]                                   pixels_read;
    vic_color_pkg::char_word_t                    char_read;
    vic_color_pkg::color_t                        b0c;
    vic_color_pkg::color_t                        b1c;
    vic_color_pkg::color_t                        b2c;
    vic_color_pkg::color_t                        b3c;
    vic_color_pkg::color_t                        ec;
    logic                                         main_border;
    logic                                         vborder;
    vic_color_pkg::sprite_code_t [NUM_SPRITES-1:0] sprite_code;
    logic [NUM_SPRITES-1:0]                       sprite_pri;
    logic [NUM_SPRITES-1:0]                       sprite_mmc;
    vic_color_pkg::color_t [NUM_SPRITES-1:0]      sprite_col;
    vic_color_pkg::color_t                        sprite_mc0;
    vic_color_pkg::color_t                        sprite_mc1;
    vic_color_pkg::color_t                        pixel_color;
    logic                                         pixel_strobe;
    vic_timing_pkg::cycle_t                       raster_cycle;
    vic_timing_pkg::dot_t                         raster_dot;
    vic_color_pkg::color_t                        exp_color [8];
    int                                           num_cases;

    tb_clock_gen i_tb_clock_gen (
        .clk_o(clk_dot4x),
        .rst_o(rst)
    );

    pixel_sequencer #(
        .NUM_SPRITES(NUM_SPRITES),
        .LINE_CYCLES(LINE_CYCLES)
    ) i_pixel_sequencer (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .mcm_i         (mcm),
        .bmm_i         (bmm),
        .ecm_i         (ecm),
        .idle_i        (idle),
        .xscroll_i     (xscroll),
        .pixels_read_i (pixels_read),
        .char_read_i   (char_read),
        .b0c_i         (b0c),
        .b1c_i         (b1c),
        .b2c_i         (b2c),
        .b3c_i         (b3c),
        .ec_i          (ec),
        .main_border_i (main_border),
        .vborder_i     (vborder),
        .sprite_code_i (sprite_code),
        .sprite_pri_i  (sprite_pri),
        .sprite_mmc_i  (sprite_mmc),
        .sprite_col_i  (sprite_col),
        .sprite_mc0_i  (sprite_mc0),
        .sprite_mc1_i  (sprite_mc1),
        .pixel_color_o (pixel_color),
        .pixel_strobe_o(pixel_strobe),
        .raster_cycle_o(raster_cycle),
        .raster_dot_o  (raster_dot)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %0t: %s is %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    // inputs change and outputs are read 2 ns after the rising edge
    task automatic step_clock();
        @(posedge clk_dot4x);
        #2;
    endtask

    task automatic drive_defaults();
        mcm         = 1'b0;
        bmm         = 1'b0;
        ecm         = 1'b0;
        idle        = 1'b0;
        xscroll     = '0;
        pixels_read = '0;
        char_read   = '0;
        b0c         = '0;
        b1c         = '0;
        b2c         = '0;
        b3c         = '0;
        ec          = '0;
        main_border = 1'b0;
        vborder     = 1'b0;
        sprite_code = '0;
        sprite_pri  = '0;
        sprite_mmc  = '0;
        sprite_col  = '0;
        sprite_mc0  = '0;
        sprite_mc1  = '0;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        step_clock();
        while (rst !== 1'b0) begin
            if (waited == RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
            step_clock();
            waited++;
        end
    endtask

    // each step of the raster cycle is one phi period and wraps at the line length
    task automatic wait_for_cycle(input int target);
        int waited;
        int prev_cycle;
        int since_change;
        bit seen_change;
        waited       = 0;
        prev_cycle   = int'(raster_cycle);
        since_change = 0;
        seen_change  = 1'b0;
        while (int'(raster_cycle) != target) begin
            if (waited == CYCLE_TIMEOUT) begin
                abort_run($sformatf("raster cycle %0d was never reached", target));
            end
            step_clock();
            waited++;
            since_change++;
            if (int'(raster_cycle) != prev_cycle) begin
                check_equal(32'(raster_cycle), 32'((prev_cycle + 1) % LINE_CYCLES),
                            "raster cycle step");
                if (seen_change) begin
                    check_equal(32'(since_change), 32'(PHI_CLOCKS), "phi cycle length");
                end
                prev_cycle   = int'(raster_cycle);
                since_change = 0;
                seen_change  = 1'b1;
            end
        end
    endtask

    // pixel k of the byte shows at dot (xscroll + 2 + k) mod 8
    task automatic collect_pixels(input int case_idx);
        int                   waited;
        int                   got;
        logic [7:0]           seen;
        vic_timing_pkg::dot_t k;
        waited = 0;
        got    = 0;
        seen   = '0;
        while (got < 8) begin
            if (waited == STROBE_TIMEOUT) begin
                abort_run($sformatf("case %0d: pixel strobes stopped", case_idx));
            end
            step_clock();
            waited++;
            if (pixel_strobe) begin
                k = raster_dot - xscroll - 3'd2;
                check_equal(32'(pixel_color), 32'(exp_color[k]),
                            $sformatf("case %0d pixel %0d at dot %0d", case_idx, k, raster_dot));
                seen[raster_dot] = 1'b1;
                got++;
            end
        end
        check_equal(32'(seen), 32'hff, $sformatf("case %0d dot coverage", case_idx));
    endtask

    function automatic bit is_data_line(input string text);
        bit result;
        result = 1'b1;
        if (text.len() == 0) begin
            result = 1'b0;
        end else if (text.getc(0) == "#" || text.getc(0) == "\n" || text.getc(0) == "\r") begin
            result = 1'b0;
        end
        return result;
    endfunction

    initial begin
        int    fd;
        int    nread;
        string text_line;
        num_cases = 0;
        drive_defaults();
        wait_reset_release();
        fd = $fopen("test/pixel_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open test/pixel_vectors.txt");
        end
        while ($fgets(text_line, fd) > 0) begin
            if (is_data_line(text_line)) begin
                step_clock();
                nread = $sscanf(text_line,
                                "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                                mcm, bmm, ecm, idle, xscroll, pixels_read, char_read,
                                b0c, b1c, b2c, b3c, ec, main_border, vborder,
                                sprite_code, sprite_pri, sprite_mmc, sprite_col,
                                sprite_mc0, sprite_mc1,
                                exp_color[0], exp_color[1], exp_color[2], exp_color[3],
                                exp_color[4], exp_color[5], exp_color[6], exp_color[7]);
                if (nread != NUM_FIELDS) begin
                    abort_run($sformatf("vector line has %0d fields instead of %0d",
                                        nread, NUM_FIELDS));
                end
                num_cases++;
                // a whole line of settled inputs before the checked cycle
                wait_for_cycle(0);
                wait_for_cycle(CHECK_CYCLE);
                collect_pixels(num_cases);
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            abort_run("no test vectors found in test/pixel_vectors.txt");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    // 40 ns clk_dot4x
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

    // released just after the tenth rising edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

// File: hw/pixel_sequencer.sv
module pixel_sequencer #(
    parameter int NUM_SPRITES = 8,
    parameter int LINE_CYCLES = vic_timing_pkg::CYCLES_PER_LINE
) (
    input  logic                                          clk_dot4x,
    input  logic                                          rst,
    input  logic                                          mcm_i,
    input  logic                                          bmm_i,
    input  logic                                          ecm_i,
    input  logic                                          idle_i,
    input  vic_timing_pkg::dot_t                          xscroll_i,
    input  logic [7:0]                                    pixels_read_i,
    input  vic_color_pkg::char_word_t                     char_read_i,
    input  vic_color_pkg::color_t                         b0c_i,
    input  vic_color_pkg::color_t                         b1c_i,
    input  vic_color_pkg::color_t                         b2c_i,
    input  vic_color_pkg::color_t                         b3c_i,
    input  vic_color_pkg::color_t                         ec_i,
    input  logic                                          main_border_i,
    input  logic                                          vborder_i,
    input  vic_color_pkg::sprite_code_t [NUM_SPRITES-1:0] sprite_code_i,
    input  logic [NUM_SPRITES-1:0]                        sprite_pri_i,
    input  logic [NUM_SPRITES-1:0]                        sprite_mmc_i,
    input  vic_color_pkg::color_t [NUM_SPRITES-1:0]       sprite_col_i,
    input  vic_color_pkg::color_t                         sprite_mc0_i,
    input  vic_color_pkg::color_t                         sprite_mc1_i,
    output vic_color_pkg::color_t                         pixel_color_o,
    output logic                                          pixel_strobe_o,
    output vic_timing_pkg::cycle_t                        raster_cycle_o,
    output vic_timing_pkg::dot_t                          raster_dot_o
);

    logic                      dot_rise0;
    logic                      dot_rise1;
    logic                      dav_stb;
    logic                      pl_stb;
    logic                      xscroll_stb;
    logic                      stage0_stb;
    logic                      stage1_stb;
    vic_timing_pkg::dot_t      dot_idx;
    vic_timing_pkg::cycle_t    cycle_num;
    vic_timing_pkg::dot_t      xscroll_held;
    logic [7:0]                pixels_ready;
    vic_color_pkg::char_word_t char_ready;
    vic_color_pkg::char_word_t char_shift;
    logic [1:0]                gfx_bits;
    logic                      bg_pixel;
    vic_color_pkg::color_t     color1;
    logic                      bg1;
    logic                      border1;

    // raster position for the sprite and border logic outside
    assign raster_cycle_o = cycle_num;
    assign raster_dot_o   = dot_idx;

    dot_phase_gen #(
        .LINE_CYCLES(LINE_CYCLES)
    ) i_dot_phase_gen (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .dot_rise0_o  (dot_rise0),
        .dot_rise1_o  (dot_rise1),
        .dav_stb_o    (dav_stb),
        .pl_stb_o     (pl_stb),
        .xscroll_stb_o(xscroll_stb),
        .dot_idx_o    (dot_idx),
        .cycle_num_o  (cycle_num)
    );

    char_fetch_latch i_char_fetch_latch (
        .clk_dot4x     (clk_dot4x),
        .dav_stb_i     (dav_stb),
        .pl_stb_i      (pl_stb),
        .xscroll_stb_i (xscroll_stb),
        .cycle_num_i   (cycle_num),
        .pixels_read_i (pixels_read_i),
        .char_read_i   (char_read_i),
        .xscroll_i     (xscroll_i),
        .pixels_ready_o(pixels_ready),
        .char_ready_o  (char_ready),
        .xscroll_held_o(xscroll_held)
    );

    pixel_shifter i_pixel_shifter (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .dot_rise0_i   (dot_rise0),
        .dot_rise1_i   (dot_rise1),
        .dot_idx_i     (dot_idx),
        .cycle_num_i   (cycle_num),
        .xscroll_held_i(xscroll_held),
        .pixels_ready_i(pixels_ready),
        .char_ready_i  (char_ready),
        .mcm_i         (mcm_i),
        .bmm_i         (bmm_i),
        .ecm_i         (ecm_i),
        .idle_i        (idle_i),
        .vborder_i     (vborder_i),
        .gfx_bits_o    (gfx_bits),
        .char_shift_o  (char_shift),
        .bg_pixel_o    (bg_pixel),
        .stage0_stb_o  (stage0_stb)
    );

    mode_color_sel i_mode_color_sel (
        .clk_dot4x    (clk_dot4x),
        .stage0_stb_i (stage0_stb),
        .gfx_bits_i   (gfx_bits),
        .char_shift_i (char_shift),
        .bg_pixel_i   (bg_pixel),
        .main_border_i(main_border_i),
        .mcm_i        (mcm_i),
        .bmm_i        (bmm_i),
        .ecm_i        (ecm_i),
        .b0c_i        (b0c_i),
        .b1c_i        (b1c_i),
        .b2c_i        (b2c_i),
        .b3c_i        (b3c_i),
        .color1_o     (color1),
        .bg1_o        (bg1),
        .border1_o    (border1),
        .stage1_stb_o (stage1_stb)
    );

    sprite_border_mix #(
        .NUM_SPRITES(NUM_SPRITES)
    ) i_sprite_border_mix (
        .clk_dot4x     (clk_dot4x),
        .stage1_stb_i  (stage1_stb),
        .dot_rise1_i   (dot_rise1),
        .color1_i      (color1),
        .bg1_i         (bg1),
        .border1_i     (border1),
        .mcm_i         (mcm_i),
        .bmm_i         (bmm_i),
        .ecm_i         (ecm_i),
        .sprite_code_i (sprite_code_i),
        .sprite_pri_i  (sprite_pri_i),
        .sprite_mmc_i  (sprite_mmc_i),
        .sprite_col_i  (sprite_col_i),
        .sprite_mc0_i  (sprite_mc0_i),
        .sprite_mc1_i  (sprite_mc1_i),
        .ec_i          (ec_i),
        .pixel_color_o (pixel_color_o),
        .pixel_strobe_o(pixel_strobe_o)
    );

endmodule

// File: hw/sprite_border_mix.sv
module sprite_border_mix #(
    parameter int NUM_SPRITES = 8
) (
    input  logic                                        clk_dot4x,
    input  logic                                        stage1_stb_i,
    input  logic                                        dot_rise1_i,
    input  vic_color_pkg::color_t                       color1_i,
    input  logic                                        bg1_i,
    input  logic                                        border1_i,
    input  logic                                        mcm_i,
    input  logic                                        bmm_i,
    input  logic                                        ecm_i,
    input  vic_color_pkg::sprite_code_t [NUM_SPRITES-1:0] sprite_code_i,
    input  logic [NUM_SPRITES-1:0]                      sprite_pri_i,
    input  logic [NUM_SPRITES-1:0]                      sprite_mmc_i,
    input  vic_color_pkg::color_t [NUM_SPRITES-1:0]     sprite_col_i,
    input  vic_color_pkg::color_t                       sprite_mc0_i,
    input  vic_color_pkg::color_t                       sprite_mc1_i,
    input  vic_color_pkg::color_t                       ec_i,
    output vic_color_pkg::color_t                       pixel_color_o,
    output logic                                        pixel_strobe_o
);

    vic_color_pkg::gfx_mode_e mode;
    logic                     illegal;
    vic_color_pkg::color_t    gfx_color;
    vic_color_pkg::color_t    mix_color;
    vic_color_pkg::color_t    color2;
    vic_color_pkg::color_t    color_dly;
    logic                     border2;
    logic                     border_dly;
    logic                     strobe_d;

    assign mode    = vic_color_pkg::gfx_mode_e'({ecm_i, bmm_i, mcm_i});
    assign illegal = mode inside {vic_color_pkg::mode_inv_ecm_mc_char,
                                  vic_color_pkg::mode_inv_ecm_bitmap,
                                  vic_color_pkg::mode_inv_ecm_mc_bitmap};
    assign gfx_color = illegal ? vic_color_pkg::COLOR_BLACK : color1_i;

    // walk down so that sprite 0 is applied last and wins
    always_comb begin
        mix_color = gfx_color;
        for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprite_pri_i[n] || bg1_i) begin
                if (sprite_mmc_i[n]) begin
                    case (sprite_code_i[n])
                        2'b01:   mix_color = sprite_mc0_i;
                        2'b10:   mix_color = sprite_col_i[n];
                        2'b11:   mix_color = sprite_mc1_i;
                        default: ;
                    endcase
                end else if (sprite_code_i[n][1]) begin
                    mix_color = sprite_col_i[n];
                end
            end
            // a behind-foreground sprite undoes what lower sprites drew
            if (sprite_pri_i[n] && !bg1_i &&
                (sprite_mmc_i[n] ? sprite_code_i[n] != 2'b00 : sprite_code_i[n][1])) begin
                mix_color = gfx_color;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        strobe_d       <= dot_rise1_i;
        pixel_strobe_o <= strobe_d;
        if (stage1_stb_i) begin
            color2  <= mix_color;
            border2 <= border1_i;
        end
        // one extra dot of delay
        if (dot_rise1_i) begin
            color_dly  <= color2;
            border_dly <= border2;
        end
        pixel_color_o <= border_dly ? ec_i : color_dly;
    end

endmodule

// File: hw/mode_color_sel.sv
module mode_color_sel (
    input  logic                       clk_dot4x,
    input  logic                       stage0_stb_i,
    input  logic [1:0]                 gfx_bits_i,
    input  vic_color_pkg::char_word_t  char_shift_i,
    input  logic                       bg_pixel_i,
    input  logic                       main_border_i,
    input  logic                       mcm_i,
    input  logic                       bmm_i,
    input  logic                       ecm_i,
    input  vic_color_pkg::color_t      b0c_i,
    input  vic_color_pkg::color_t      b1c_i,
    input  vic_color_pkg::color_t      b2c_i,
    input  vic_color_pkg::color_t      b3c_i,
    output vic_color_pkg::color_t      color1_o,
    output logic                       bg1_o,
    output logic                       border1_o,
    output logic                       stage1_stb_o
);

    vic_color_pkg::gfx_mode_e mode;
    vic_color_pkg::color_t    nib;
    vic_color_pkg::color_t    code_hi;
    vic_color_pkg::color_t    code_lo;
    vic_color_pkg::color_t    hires_char;
    vic_color_pkg::color_t    mc_char;
    vic_color_pkg::color_t    mc_bitmap;
    vic_color_pkg::color_t    ecm_color;
    vic_color_pkg::color_t    sel_color;
    logic                     mc_cell;

    assign mode    = vic_color_pkg::gfx_mode_e'({ecm_i, bmm_i, mcm_i});
    assign nib     = char_shift_i[11:8];
    assign code_hi = char_shift_i[7:4];
    assign code_lo = char_shift_i[3:0];
    // multicolour char cells are flagged by bit 11 of the colour nibble
    assign mc_cell = char_shift_i[11];

    assign hires_char = gfx_bits_i[1] ? nib : b0c_i;

    always_comb begin
        case (gfx_bits_i)
            2'b00:   mc_char = b0c_i;
            2'b01:   mc_char = b1c_i;
            2'b10:   mc_char = b2c_i;
            default: mc_char = {1'b0, nib[2:0]};
        endcase
        case (gfx_bits_i)
            2'b00:   mc_bitmap = b0c_i;
            2'b01:   mc_bitmap = code_hi;
            2'b10:   mc_bitmap = code_lo;
            default: mc_bitmap = nib;
        endcase
        // clear bit picks one of four backgrounds by code bits 7:6
        if (gfx_bits_i[1]) begin
            ecm_color = nib;
        end else begin
            case (char_shift_i[7:6])
                2'b00:   ecm_color = b0c_i;
                2'b01:   ecm_color = b1c_i;
                2'b10:   ecm_color = b2c_i;
                default: ecm_color = b3c_i;
            endcase
        end
    end

    // illegal modes still decode here, the mixer blanks them later
    always_comb begin
        case (mode)
            vic_color_pkg::mode_mc_char:
                sel_color = mc_cell ? mc_char : hires_char;
            vic_color_pkg::mode_std_bitmap, vic_color_pkg::mode_inv_ecm_bitmap:
                sel_color = gfx_bits_i[1] ? code_hi : code_lo;
            vic_color_pkg::mode_mc_bitmap, vic_color_pkg::mode_inv_ecm_mc_bitmap:
                sel_color = mc_bitmap;
            vic_color_pkg::mode_ecm_char:
                sel_color = ecm_color;
            vic_color_pkg::mode_inv_ecm_mc_char:
                sel_color = mc_cell ? mc_char : ecm_color;
            default:
                sel_color = hires_char;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        stage1_stb_o <= stage0_stb_i;
        if (stage0_stb_i) begin
            color1_o  <= sel_color;
            bg1_o     <= bg_pixel_i;
            border1_o <= main_border_i;
        end
    end

endmodule

// File: hw/pixel_shifter.sv
module pixel_shifter (
    input  logic                       clk_dot4x,
    input  logic                       rst,
    input  logic                       dot_rise0_i,
    input  logic                       dot_rise1_i,
    input  vic_timing_pkg::dot_t       dot_idx_i,
    input  vic_timing_pkg::cycle_t     cycle_num_i,
    input  vic_timing_pkg::dot_t       xscroll_held_i,
    input  logic [7:0]                 pixels_ready_i,
    input  vic_color_pkg::char_word_t  char_ready_i,
    input  logic                       mcm_i,
    input  logic                       bmm_i,
    input  logic                       ecm_i,
    input  logic                       idle_i,
    input  logic                       vborder_i,
    output logic [1:0]                 gfx_bits_o,
    output vic_color_pkg::char_word_t  char_shift_o,
    output logic                       bg_pixel_o,
    output logic                       stage0_stb_o
);

    logic [7:0]                pix_shift;
    vic_color_pkg::char_word_t char_cur;
    logic                      shift_en;
    logic                      load;
    logic                      ismc;
    logic                      active;

    assign load   = dot_idx_i == xscroll_held_i;
    assign ismc   = mcm_i & (bmm_i | ecm_i | char_cur[11]);
    assign active = !vborder_i &&
                    cycle_num_i >= vic_timing_pkg::VISIBLE_FIRST &&
                    cycle_num_i <= vic_timing_pkg::VISIBLE_LAST;

    // in multicolour the enable toggles, so each bit pair is held two dots
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_en <= 1'b0;
        end else if (dot_rise0_i) begin
            if (load) begin
                shift_en <= 1'b1;
            end else if (ismc) begin
                shift_en <= ~shift_en;
            end
        end
    end

    // char word for the current cell, cleared while idle
    always_ff @(posedge clk_dot4x) begin
        if (dot_rise1_i && active) begin
            if (idle_i) begin
                char_cur <= '0;
            end else if (load) begin
                char_cur <= char_ready_i;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pix_shift    <= '0;
            gfx_bits_o   <= '0;
            bg_pixel_o   <= 1'b0;
            stage0_stb_o <= 1'b0;
        end else begin
            stage0_stb_o <= dot_rise1_i;
            if (dot_rise1_i) begin
                // output stage takes the bits shown during the last dot
                gfx_bits_o   <= pix_shift[7:6];
                bg_pixel_o   <= !pix_shift[7];
                char_shift_o <= char_cur;
                if (load) begin
                    pix_shift <= active ? pixels_ready_i : 8'h00;
                end else if (shift_en) begin
                    pix_shift <= ismc ? {pix_shift[5:0], 2'b00} : {pix_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: hw/char_fetch_latch.sv
module char_fetch_latch (
    input  logic                       clk_dot4x,
    input  logic                       dav_stb_i,
    input  logic                       pl_stb_i,
    input  logic                       xscroll_stb_i,
    input  vic_timing_pkg::cycle_t     cycle_num_i,
    input  logic [7:0]                 pixels_read_i,
    input  vic_color_pkg::char_word_t  char_read_i,
    input  vic_timing_pkg::dot_t       xscroll_i,
    output logic [7:0]                 pixels_ready_o,
    output vic_color_pkg::char_word_t  char_ready_o,
    output vic_timing_pkg::dot_t       xscroll_held_o
);

    logic [7:0]                pixels_d0;
    logic [7:0]                pixels_d1;
    vic_color_pkg::char_word_t char_d0;
    vic_color_pkg::char_word_t char_d1;
    logic                      visible;

    assign visible = cycle_num_i >= vic_timing_pkg::VISIBLE_FIRST &&
                     cycle_num_i <= vic_timing_pkg::VISIBLE_LAST;

    always_ff @(posedge clk_dot4x) begin
        // two phi cycles of delay so the data is ready when the shifter loads
        if (dav_stb_i) begin
            pixels_d0 <= pixels_read_i;
            pixels_d1 <= pixels_d0;
            char_d0   <= char_read_i;
            char_d1   <= char_d0;
        end
        if (pl_stb_i) begin
            pixels_ready_o <= pixels_d1;
            char_ready_o   <= char_d1;
        end
        // x-scroll only changes inside the display window
        if (xscroll_stb_i && visible) begin
            xscroll_held_o <= xscroll_i;
        end
    end

endmodule

// File: hw/dot_phase_gen.sv
module dot_phase_gen #(
    parameter int LINE_CYCLES = 63
) (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    output logic                   dot_rise0_o,
    output logic                   dot_rise1_o,
    output logic                   dav_stb_o,
    output logic                   pl_stb_o,
    output logic                   xscroll_stb_o,
    output vic_timing_pkg::dot_t   dot_idx_o,
    output vic_timing_pkg::cycle_t cycle_num_o
);

    // 32 clocks per phi cycle, 4 per dot
    logic [4:0]              phase;
    logic [4:0]              phase_nxt;
    vic_timing_pkg::subdot_t subdot_nxt;

    assign phase_nxt  = phase + 5'd1;
    assign subdot_nxt = phase_nxt[1:0];
    assign dot_idx_o  = phase[4:2];

    // strobes are registered from the next phase value
    // so they line up with the counter they decode
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase         <= '0;
            cycle_num_o   <= '0;
            dot_rise0_o   <= 1'b0;
            dot_rise1_o   <= 1'b0;
            dav_stb_o     <= 1'b0;
            pl_stb_o      <= 1'b0;
            xscroll_stb_o <= 1'b0;
        end else begin
            phase         <= phase_nxt;
            dot_rise0_o   <= subdot_nxt == 2'd0;
            dot_rise1_o   <= subdot_nxt == 2'd1;
            dav_stb_o     <= phase_nxt == vic_timing_pkg::DAV_POS;
            pl_stb_o      <= phase_nxt == vic_timing_pkg::PL_POS;
            xscroll_stb_o <= phase_nxt == vic_timing_pkg::XSCROLL_POS;
            // next phi cycle starts when the phase wraps
            if (phase == 5'd31) begin
                if (cycle_num_o == vic_timing_pkg::cycle_t'(LINE_CYCLES - 1)) begin
                    cycle_num_o <= '0;
                end else begin
                    cycle_num_o <= cycle_num_o + 7'd1;
                end
            end
        end
    end

endmodule

// File: hw/vic_color_pkg.sv
package vic_color_pkg;

    // palette index
    typedef logic [3:0] color_t;

    localparam color_t COLOR_BLACK = 4'd0;

    // display mode, encoded as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        mode_std_char          = 3'b000,
        mode_mc_char           = 3'b001,
        mode_std_bitmap        = 3'b010,
        mode_mc_bitmap         = 3'b011,
        mode_ecm_char          = 3'b100,
        mode_inv_ecm_mc_char   = 3'b101,
        mode_inv_ecm_bitmap    = 3'b110,
        mode_inv_ecm_mc_bitmap = 3'b111
    } gfx_mode_e;

    // colour nibble in [11:8], character code in [7:0]
    typedef logic [11:0] char_word_t;

    // per-dot sprite pixel code
    typedef logic [1:0] sprite_code_t;

endpackage

// File: hw/vic_timing_pkg.sv
package vic_timing_pkg;

    // phi cycle number within a raster line
    typedef logic [6:0] cycle_t;

    // dot index within a phi cycle (xpos mod 8)
    typedef logic [2:0] dot_t;

    // clk_dot4x position within one dot
    typedef logic [1:0] subdot_t;

    // default line length in phi cycles
    parameter int CYCLES_PER_LINE = 63;

    // first and last cycles that carry graphics
    localparam cycle_t VISIBLE_FIRST = 7'd15;
    localparam cycle_t VISIBLE_LAST  = 7'd56;

    // strobe positions inside the 32 clock phi period
    // dav sits late enough that the bus data has settled
    localparam logic [4:0] DAV_POS     = 5'd20;
    localparam logic [4:0] XSCROLL_POS = 5'd28;
    localparam logic [4:0] PL_POS      = 5'd31;

endpackage
